/* Makefile */
VERILATOR  ?= verilator
TOP        := int_exec_unit_tb
RTL_TOP    := int_exec_unit
FILELIST   := int_exec_unit.f
OBJ_DIR    := obj_dir
SIM_BIN    := sim_bin
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
PASS_MSG   := test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass is decided by the message in the simulator output
sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST) -o $(SIM_BIN)
	./$(OBJ_DIR)/$(SIM_BIN) | awk '{ print } /$(PASS_MSG)/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

/* exec_pkg.sv */
////////////////////////////////////////
// execute-side definitions
// alu operation codes, decoded control and writeback record
////////////////////////////////////////

package exec_pkg;

	// datapath width, fixed by rv32
	localparam int xlen = 32;

	// alu operation codes
	// encoding kept from the older alu so waveforms read the same
	typedef enum logic [3:0] {
		alu_add    = 4'b0000,
		alu_sub    = 4'b0001,
		alu_sll    = 4'b0010,
		alu_slt    = 4'b0011,
		alu_sltu   = 4'b0100,
		alu_xor    = 4'b0101,
		alu_srl    = 4'b0110,
		alu_sra    = 4'b0111,
		alu_or     = 4'b1000,
		alu_and    = 4'b1001,
		alu_pass_b = 4'b1010
	} alu_op_t;

	// decoder output, one per instruction word
	typedef struct packed {
		logic            wr_en;
		logic            illegal;
		alu_op_t         alu_op;
		logic [4:0]      rs1;
		logic [4:0]      rs2;
		logic [4:0]      rd;
		// second operand comes from imm instead of rs2
		logic            use_imm;
		logic [xlen-1:0] imm;
	} dec_ctrl_t;

	// registered result presented at the top level
	typedef struct packed {
		logic            valid;
		logic [4:0]      rd;
		logic [xlen-1:0] data;
	} wb_t;

endpackage

/* int_alu.sv */
////////////////////////////////////////
// 32-bit integer alu
// shared add/sub carry path, shifts, compares and logic ops
////////////////////////////////////////

`timescale 1ns/1ps

module int_alu (
	input  exec_pkg::alu_op_t        op,
	input  logic [exec_pkg::xlen-1:0] src1,
	input  logic [exec_pkg::xlen-1:0] src2,
	output logic [exec_pkg::xlen-1:0] result,
	output logic                      zero,
	output logic                      sign
);

	logic                      sub_sel;
	logic [exec_pkg::xlen-1:0] b_in;
	logic [exec_pkg::xlen-1:0] sum;
	logic                      carry;
	logic                      ovf;
	logic                      lt_s;
	logic                      lt_u;
	logic [4:0]                shamt;

	// compares run through the subtractor as well
	assign sub_sel = (op == exec_pkg::alu_sub) ||
		(op == exec_pkg::alu_slt) ||
		(op == exec_pkg::alu_sltu);

	// two's complement subtract as src1 + ~src2 + 1
	assign b_in = sub_sel ? ~src2 : src2;

	// one 33-bit adder, top bit is the carry out
	assign {carry, sum} = {1'b0, src1} + {1'b0, b_in} + {{exec_pkg::xlen{1'b0}}, sub_sel};

	// signed overflow: operands of equal sign, result sign differs
	assign ovf = (src1[exec_pkg::xlen-1] == b_in[exec_pkg::xlen-1]) &&
		(sum[exec_pkg::xlen-1] != src1[exec_pkg::xlen-1]);

	// signed less-than corrects the raw sign by the overflow
	assign lt_s = sum[exec_pkg::xlen-1] ^ ovf;

	// no carry out of the subtract means a borrow, so src1 < src2
	assign lt_u = !carry;

	// only the low five bits count
	assign shamt = src2[4:0];

	always_comb begin
		case (op)
			exec_pkg::alu_add,
			exec_pkg::alu_sub: begin
				result = sum;
			end
			exec_pkg::alu_sll: begin
				result = src1 << shamt;
			end
			exec_pkg::alu_slt: begin
				result = {{(exec_pkg::xlen-1){1'b0}}, lt_s};
			end
			exec_pkg::alu_sltu: begin
				result = {{(exec_pkg::xlen-1){1'b0}}, lt_u};
			end
			exec_pkg::alu_xor: begin
				result = src1 ^ src2;
			end
			exec_pkg::alu_srl: begin
				result = src1 >> shamt;
			end
			exec_pkg::alu_sra: begin
				// arithmetic shift fills with the sign bit
				result = $unsigned($signed(src1) >>> shamt);
			end
			exec_pkg::alu_or: begin
				result = src1 | src2;
			end
			exec_pkg::alu_and: begin
				result = src1 & src2;
			end
			exec_pkg::alu_pass_b: begin
				// lui path
				result = src2;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// flags describe the final result
	assign zero = (result == '0);
	assign sign = result[exec_pkg::xlen-1];

endmodule

/* int_decoder.sv */
////////////////////////////////////////
// integer instruction decoder
// maps op, op-imm and lui words to alu control plus immediate
////////////////////////////////////////

`timescale 1ns/1ps

module int_decoder (
	input  rv_isa_pkg::instr_u  instr,
	output exec_pkg::dec_ctrl_t ctrl
);

	logic [6:0]        opcode;
	logic [2:0]        funct3;
	logic [6:0]        funct7;
	logic              alt;
	logic              f7_ok;
	logic              imm_ok;
	exec_pkg::alu_op_t base_op;

	// opcode and funct fields sit at the same place in every view
	assign opcode = instr.r.opcode;
	assign funct3 = instr.r.funct3;
	// for op-imm this is imm[11:5]
	assign funct7 = instr.r.funct7;
	assign alt    = (funct7 == rv_isa_pkg::f7_alt);

	// funct7 legality for op and for op-imm shifts
	// zero always ok, alt only with add (sub) and sr (sra)
	assign f7_ok = (funct7 == 7'd0) ||
		(alt && (funct3 == rv_isa_pkg::f3_add || funct3 == rv_isa_pkg::f3_sr));

	// op-imm legality by funct3
	always_comb begin
		case (funct3)
			// shift amount only in imm[4:0], upper bits act as funct7
			rv_isa_pkg::f3_sll, rv_isa_pkg::f3_sr: imm_ok = f7_ok;
			// no subi, an alt pattern on addi is rejected
			rv_isa_pkg::f3_add: imm_ok = !alt;
			default: imm_ok = 1'b1;
		endcase
	end

	// funct3 to alu operation, alt bit picks sub and sra
	always_comb begin
		case (funct3)
			rv_isa_pkg::f3_add:  base_op = alt ? exec_pkg::alu_sub : exec_pkg::alu_add;
			rv_isa_pkg::f3_sll:  base_op = exec_pkg::alu_sll;
			rv_isa_pkg::f3_slt:  base_op = exec_pkg::alu_slt;
			rv_isa_pkg::f3_sltu: base_op = exec_pkg::alu_sltu;
			rv_isa_pkg::f3_xor:  base_op = exec_pkg::alu_xor;
			rv_isa_pkg::f3_sr:   base_op = alt ? exec_pkg::alu_sra : exec_pkg::alu_srl;
			rv_isa_pkg::f3_or:   base_op = exec_pkg::alu_or;
			default:             base_op = exec_pkg::alu_and;
		endcase
	end

	always_comb begin
		ctrl        = '0;
		ctrl.alu_op = base_op;
		// register fields taken as they are, unused ones are harmless
		ctrl.rs1    = instr.r.rs1;
		ctrl.rs2    = instr.r.rs2;
		ctrl.rd     = instr.r.rd;
		case (opcode)
			rv_isa_pkg::opc_op: begin
				ctrl.wr_en   = f7_ok;
				ctrl.illegal = !f7_ok;
			end
			rv_isa_pkg::opc_op_imm: begin
				ctrl.use_imm = 1'b1;
				// sign-extended 12-bit immediate
				ctrl.imm     = {{20{instr.i.imm[11]}}, instr.i.imm};
				ctrl.wr_en   = imm_ok;
				ctrl.illegal = !imm_ok;
			end
			rv_isa_pkg::opc_lui: begin
				ctrl.use_imm = 1'b1;
				// upper immediate, low 12 bits zero
				ctrl.imm     = {instr.u.imm, 12'd0};
				ctrl.alu_op  = exec_pkg::alu_pass_b;
				ctrl.wr_en   = 1'b1;
			end
			default: begin
				// anything else is outside this slice
				ctrl.illegal = 1'b1;
			end
		endcase
	end

endmodule

/* int_exec_unit.f */
rv_isa_pkg.sv
exec_pkg.sv
int_decoder.sv
int_alu.sv
reg_file.sv
int_exec_unit.sv
int_exec_unit_asserts.sv
int_exec_unit_tb.sv

/* int_exec_unit.sv */
////////////////////////////////////////
// integer execute slice, top level
// decode, register read, alu and registered writeback
////////////////////////////////////////

`timescale 1ns/1ps

module int_exec_unit (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          instr_valid,
	input  logic [31:0]   instr,
	output exec_pkg::wb_t wb,
	output logic          illegal
);

	rv_isa_pkg::instr_u        instr_w;
	exec_pkg::dec_ctrl_t       ctrl;
	logic [exec_pkg::xlen-1:0] rs1_data;
	logic [exec_pkg::xlen-1:0] rs2_data;
	logic [exec_pkg::xlen-1:0] src2;
	logic [exec_pkg::xlen-1:0] result;
	logic                      ins_ok;
	logic                      rf_we;
	logic                      valid_q;
	logic                      illegal_q;
	logic [4:0]                rd_q;
	logic [exec_pkg::xlen-1:0] data_q;

	// raw word into the union, decoder picks the view
	assign instr_w = instr;

	int_decoder int_decoder_i (
		.instr (instr_w),
		.ctrl  (ctrl)
	);

	// legal and strobed this cycle
	assign ins_ok = instr_valid && ctrl.wr_en && !ctrl.illegal;

	// x0 writes dropped here as well as in the register file
	assign rf_we = ins_ok && (ctrl.rd != 5'd0);

	reg_file reg_file_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1_addr (ctrl.rs1),
		.rs2_addr (ctrl.rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wr_en    (rf_we),
		.wr_addr  (ctrl.rd),
		.wr_data  (result)
	);

	// second operand: immediate or rs2
	assign src2 = ctrl.use_imm ? ctrl.imm : rs2_data;

	// flags not needed in this slice
	int_alu int_alu_i (
		.op     (ctrl.alu_op),
		.src1   (rs1_data),
		.src2   (src2),
		.result (result),
		.zero   (),
		.sign   ()
	);

	// output strobes, one cycle after instr_valid
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q   <= 1'b0;
			illegal_q <= 1'b0;
		end else begin
			// rd of zero still reports, only the write is dropped
			valid_q   <= ins_ok;
			illegal_q <= instr_valid && ctrl.illegal;
		end
	end

	// payload held between strobes
	always_ff @(posedge clk) begin
		if (instr_valid) begin
			rd_q   <= ctrl.rd;
			data_q <= result;
		end
	end

	assign wb      = '{valid: valid_q, rd: rd_q, data: data_q};
	assign illegal = illegal_q;

endmodule

/* int_exec_unit_asserts.sv */
////////////////////////////////////////
// output protocol checks
// bound to the integer execute slice
////////////////////////////////////////

`timescale 1ns/1ps

module int_exec_unit_asserts (
	input logic          clk,
	input logic          rst_n,
	input logic          instr_valid,
	input logic [31:0]   instr,
	input exec_pkg::wb_t wb,
	input logic          illegal
);

	// number of failed properties so far
	int fail_count = 0;

	// a result and an illegal pulse exclude each other
	one_hot_out: assert property (@(posedge clk) disable iff (!rst_n)
		!(wb.valid && illegal))
		else begin
			fail_count++;
			$error("wb.valid and illegal are high together");
		end

	// no strobe means no pulse one cycle later
	quiet_out: assert property (@(posedge clk) disable iff (!rst_n)
		!instr_valid |=> !wb.valid && !illegal)
		else begin
			fail_count++;
			$error("output pulse without instr_valid in the cycle before");
		end

	// rd of the writeback is the rd field of the strobed word
	rd_match: assert property (@(posedge clk) disable iff (!rst_n)
		instr_valid |=> !wb.valid || (wb.rd == $past(instr[11:7])))
		else begin
			fail_count++;
			$error("wb.rd differs from the rd field of the instruction");
		end

endmodule

bind int_exec_unit int_exec_unit_asserts asserts_i (
	.clk         (clk),
	.rst_n       (rst_n),
	.instr_valid (instr_valid),
	.instr       (instr),
	.wb          (wb),
	.illegal     (illegal)
);

/* int_exec_unit_tb.sv */
////////////////////////////////////////
// testbench for the integer execute slice
// directed tests checked against a model register file
////////////////////////////////////////

`timescale 1ns/1ps

module int_exec_unit_tb;

	localparam int timeout_cycles = 8;

	logic          clk;
	logic          rst_n;
	logic          instr_valid;
	logic [31:0]   instr;
	exec_pkg::wb_t wb;
	logic          illegal;

	// architectural state as the tests expect it, x0 stays zero
	logic [31:0] model_regs [32];
	integer      seed;

	int_exec_unit int_exec_unit_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb          (wb),
		.illegal     (illegal)
	);

	always #20 clk = ~clk;

	// instruction builders for the three formats
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, rv_isa_pkg::opc_op};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, rv_isa_pkg::opc_op_imm};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, rv_isa_pkg::opc_lui};
	endfunction

	// expected legality and result of one word, from the model registers
	function automatic void predict(input logic [31:0] w, output logic legal,
		output logic [31:0] res);
		logic [31:0] a;
		logic [31:0] b;
		logic        alt;
		logic        is_op;
		a     = model_regs[w[19:15]];
		is_op = (w[6:0] == rv_isa_pkg::opc_op);
		b     = is_op ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
		alt   = (w[31:25] == rv_isa_pkg::f7_alt);
		legal = 1'b1;
		res   = 32'd0;
		if (w[6:0] == rv_isa_pkg::opc_lui) begin
			res = {w[31:12], 12'd0};
		end else if (!is_op && w[6:0] != rv_isa_pkg::opc_op_imm) begin
			legal = 1'b0;
		end else begin
			// funct7 is checked on every r-type and on the immediate shifts
			if (is_op || w[14:12] == rv_isa_pkg::f3_sll || w[14:12] == rv_isa_pkg::f3_sr) begin
				legal = (w[31:25] == 7'd0) || (alt && (w[14:12] == rv_isa_pkg::f3_sr ||
					(is_op && w[14:12] == rv_isa_pkg::f3_add)));
			end else if (w[14:12] == rv_isa_pkg::f3_add) begin
				// there is no subi
				legal = !alt;
			end
			case (w[14:12])
				rv_isa_pkg::f3_add:  res = (is_op && alt) ? a - b : a + b;
				rv_isa_pkg::f3_sll:  res = a << b[4:0];
				rv_isa_pkg::f3_slt:  res = {31'd0, $signed(a) < $signed(b)};
				rv_isa_pkg::f3_sltu: res = {31'd0, a < b};
				rv_isa_pkg::f3_xor:  res = a ^ b;
				rv_isa_pkg::f3_sr:   res = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
				rv_isa_pkg::f3_or:   res = a | b;
				default:             res = a & b;
			endcase
		end
	endfunction

	// the write lands at the capturing edge
	function automatic void commit(input logic [31:0] w, input logic legal,
		input logic [31:0] res);
		if (legal && w[11:7] != 5'd0) begin
			model_regs[w[11:7]] = res;
		end
	endfunction

	// next drive point, 2 ns after the rising edge
	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
			$display("test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// waits for the output pulse of word w and compares it
	task automatic expect_out(input logic [31:0] w, input logic legal, input logic [31:0] res);
		int cycles;
		cycles = 0;
		while (!wb.valid && !illegal) begin
			if (cycles >= timeout_cycles) begin
				$display("no writeback or illegal pulse within %0d cycles", timeout_cycles);
				$display("test failed");
				$fatal(1, "timeout");
			end else begin
				step();
				cycles++;
			end
		end
		check(cycles, 0, "extra cycles before the output pulse");
		check({31'd0, wb.valid}, {31'd0, legal}, "wb.valid");
		check({31'd0, illegal}, {31'd0, !legal}, "illegal");
		if (legal) begin
			check({27'd0, wb.rd}, {27'd0, w[11:7]}, "wb.rd");
			check(wb.data, res, "wb.data");
		end
	endtask

	// one instruction on its own, outputs stay visible after return
	task automatic exec(input logic [31:0] w);
		logic        legal;
		logic [31:0] res;
		predict(w, legal, res);
		instr       = w;
		instr_valid = 1'b1;
		step();
		instr_valid = 1'b0;
		expect_out(w, legal, res);
		commit(w, legal, res);
	endtask

	task automatic exec_expect(input logic [31:0] w, input logic [31:0] exp, input string msg);
		exec(w);
		check(wb.data, exp, msg);
	endtask

	// lui plus addi, the upper part absorbs the sign of the low twelve bits
	task automatic set_reg(input logic [4:0] rd, input logic [31:0] v);
		logic [31:0] hi;
		hi = v - {{20{v[11]}}, v[11:0]};
		exec(enc_u(hi[31:12], rd));
		exec_expect(enc_i(v[11:0], rd, rv_isa_pkg::f3_add, rd), v, "register load");
	endtask

	task automatic test_reset();
		check({31'd0, wb.valid}, 32'd0, "wb.valid after reset");
		check({31'd0, illegal}, 32'd0, "illegal after reset");
		exec_expect(enc_r(7'd0, 5'd2, 5'd1, rv_isa_pkg::f3_add, 5'd3), 32'd0, "add after reset");
	endtask

	task automatic test_imm();
		logic [31:0] v;
		logic [31:0] r;
		v = $random(seed);
		r = $random(seed);
		set_reg(5'd1, v);
		exec_expect(enc_i(12'hffb, 5'd1, rv_isa_pkg::f3_add, 5'd4), v - 32'd5, "addi -5");
		exec_expect(enc_i(r[11:0] | 12'h800, 5'd1, rv_isa_pkg::f3_xor, 5'd5),
			v ^ {20'hfffff, r[11:0] | 12'h800}, "xori negative");
		exec(enc_i(r[23:12], 5'd1, rv_isa_pkg::f3_or, 5'd6));
		exec_expect(enc_i(12'hf0f, 5'd1, rv_isa_pkg::f3_and, 5'd7), v & 32'hffffff0f, "andi");
		exec_expect(enc_u(r[31:12], 5'd8), {r[31:12], 12'd0}, "lui");
		// compares on each side of the boundary
		set_reg(5'd9, 32'd5);
		exec_expect(enc_i(12'd5, 5'd9, rv_isa_pkg::f3_slt, 5'd10), 32'd0, "slti 5 < 5");
		exec_expect(enc_i(12'd6, 5'd9, rv_isa_pkg::f3_slt, 5'd10), 32'd1, "slti 5 < 6");
		set_reg(5'd9, 32'hffffffff);
		exec_expect(enc_i(12'd0, 5'd9, rv_isa_pkg::f3_slt, 5'd10), 32'd1, "slti -1 < 0");
		exec_expect(enc_i(12'hfff, 5'd9, rv_isa_pkg::f3_sltu, 5'd10), 32'd0, "sltiu max");
		set_reg(5'd11, 32'd4);
		exec_expect(enc_i(12'd5, 5'd11, rv_isa_pkg::f3_sltu, 5'd12), 32'd1, "sltiu 4 < 5");
		exec_expect(enc_i(12'd4, 5'd11, rv_isa_pkg::f3_sltu, 5'd12), 32'd0, "sltiu 4 < 4");
	endtask

	task automatic test_reg_ops();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] pa [3];
		logic [31:0] pb [3];
		logic        lt_s [3];
		logic        lt_u [3];
		for (int k = 0; k < 3; k++) begin
			a = $random(seed);
			b = $random(seed);
			set_reg(5'd1, a);
			set_reg(5'd2, b);
			exec_expect(enc_r(7'd0, 5'd2, 5'd1, rv_isa_pkg::f3_add, 5'd13), a + b, "add");
			exec_expect(enc_r(rv_isa_pkg::f7_alt, 5'd2, 5'd1, rv_isa_pkg::f3_add, 5'd14),
				a - b, "sub");
			exec(enc_r(7'd0, 5'd2, 5'd1, rv_isa_pkg::f3_and, 5'd15));
			exec(enc_r(7'd0, 5'd2, 5'd1, rv_isa_pkg::f3_or, 5'd16));
			exec(enc_r(7'd0, 5'd2, 5'd1, rv_isa_pkg::f3_xor, 5'd17));
		end
		// signed and unsigned order disagree on every pair
		pa   = '{32'h80000000, 32'hffffffff, 32'h00000005};
		pb   = '{32'h00000001, 32'h00000000, 32'h80000000};
		lt_s = '{1'b1, 1'b1, 1'b0};
		lt_u = '{1'b0, 1'b0, 1'b1};
		for (int k = 0; k < 3; k++) begin
			set_reg(5'd1, pa[k]);
			set_reg(5'd2, pb[k]);
			exec_expect(enc_r(7'd0, 5'd2, 5'd1, rv_isa_pkg::f3_slt, 5'd18), {31'd0, lt_s[k]}, "slt");
			exec_expect(enc_r(7'd0, 5'd2, 5'd1, rv_isa_pkg::f3_sltu, 5'd19), {31'd0, lt_u[k]},
				"sltu");
		end
	endtask

	task automatic test_shifts();
		logic [31:0] r;
		for (int k = 0; k < 3; k++) begin
			r = $random(seed);
			set_reg(5'd1, r);
			r = $random(seed);
			// high bits of the amount register must not count
			set_reg(5'd2, r | 32'h80000060);
			exec(enc_r(7'd0, 5'd2, 5'd1, rv_isa_pkg::f3_sll, 5'd15));
			exec(enc_r(7'd0, 5'd2, 5'd1, rv_isa_pkg::f3_sr, 5'd16));
			exec(enc_r(rv_isa_pkg::f7_alt, 5'd2, 5'd1, rv_isa_pkg::f3_sr, 5'd17));
			exec(enc_i({7'd0, r[4:0]}, 5'd1, rv_isa_pkg::f3_sll, 5'd18));
			exec(enc_i({7'd0, r[9:5]}, 5'd1, rv_isa_pkg::f3_sr, 5'd19));
			exec(enc_i({rv_isa_pkg::f7_alt, r[14:10]}, 5'd1, rv_isa_pkg::f3_sr, 5'd20));
		end
		set_reg(5'd1, 32'h80000010);
		set_reg(5'd2, 32'hffffffe4);
		exec_expect(enc_i({rv_isa_pkg::f7_alt, 5'd4}, 5'd1, rv_isa_pkg::f3_sr, 5'd21),
			32'hf8000001, "srai fills with ones");
		exec_expect(enc_r(rv_isa_pkg::f7_alt, 5'd2, 5'd1, rv_isa_pkg::f3_sr, 5'd22),
			32'hf8000001, "sra fills with ones");
	endtask

	// one word per cycle, each reading the rd of the one before
	task automatic test_chain();
		logic [31:0] w [5];
		logic        legal [5];
		logic [31:0] res [5];
		w[0] = enc_i(12'd7, 5'd0, rv_isa_pkg::f3_add, 5'd20);
		w[1] = enc_i(12'd3, 5'd20, rv_isa_pkg::f3_add, 5'd21);
		w[2] = enc_r(7'd0, 5'd20, 5'd21, rv_isa_pkg::f3_add, 5'd22);
		w[3] = enc_i(12'd2, 5'd22, rv_isa_pkg::f3_sll, 5'd23);
		w[4] = enc_r(rv_isa_pkg::f7_alt, 5'd21, 5'd23, rv_isa_pkg::f3_add, 5'd24);
		predict(w[0], legal[0], res[0]);
		commit(w[0], legal[0], res[0]);
		instr       = w[0];
		instr_valid = 1'b1;
		for (int k = 1; k < 5; k++) begin
			step();
			expect_out(w[k-1], legal[k-1], res[k-1]);
			instr = w[k];
			predict(w[k], legal[k], res[k]);
			commit(w[k], legal[k], res[k]);
		end
		step();
		instr_valid = 1'b0;
		expect_out(w[4], legal[4], res[4]);
		check(wb.data, 32'd58, "end of dependency chain");
		// x0 reports the sum but keeps zero
		set_reg(5'd1, 32'h00001234);
		exec_expect(enc_i(12'd5, 5'd1, rv_isa_pkg::f3_add, 5'd0), 32'h00001239, "addi to x0");
		exec_expect(enc_r(7'd0, 5'd0, 5'd0, rv_isa_pkg::f3_add, 5'd25), 32'd0, "x0 read back");
	endtask

	task automatic test_illegal();
		set_reg(5'd27, 32'h5a5a1234);
		// load opcode, funct7 of one on add, subi
		exec({12'd0, 5'd1, 3'b010, 5'd27, 7'b0000011});
		check({31'd0, illegal}, 32'd1, "illegal on unknown opcode");
		exec(enc_r(7'b0000001, 5'd2, 5'd1, rv_isa_pkg::f3_add, 5'd27));
		exec(enc_i({rv_isa_pkg::f7_alt, 5'd3}, 5'd1, rv_isa_pkg::f3_add, 5'd27));
		exec_expect(enc_i(12'd0, 5'd27, rv_isa_pkg::f3_add, 5'd28), 32'h5a5a1234,
			"x27 kept after illegal words");
	endtask

	initial begin
		seed        = 32'h2b2c7b33;
		clk         = 1'b0;
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = 32'd0;
		for (int k = 0; k < 32; k++) begin
			model_regs[k] = 32'd0;
		end
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		test_reset();
		test_imm();
		test_reg_ops();
		test_shifts();
		test_chain();
		test_illegal();
		// bound protocol checks count their own failures
		if (int_exec_unit_i.asserts_i.fail_count == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("test failed");
			$fatal(1, "assertion failures recorded");
		end
	end

endmodule

/* reg_file.sv */
////////////////////////////////////////
// 32 x 32 integer register file
// two async reads, one sync write, x0 reads zero
////////////////////////////////////////

`timescale 1ns/1ps

module reg_file (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [4:0]  rs1_addr,
	input  logic [4:0]  rs2_addr,
	output logic [31:0] rs1_data,
	output logic [31:0] rs2_data,
	input  logic        wr_en,
	input  logic [4:0]  wr_addr,
	input  logic [31:0] wr_data
);

	// x1..x31 only, x0 has no storage
	logic [31:0] regs [1:31];

	// all architectural registers start at zero
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != 5'd0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// combinational reads
	// a write lands at the edge, so the next cycle sees it
	assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

endmodule

/* rv_isa_pkg.sv */
////////////////////////////////////////
// rv32i instruction encoding
// major opcodes, funct codes and the three field views of one
// instruction word used by the execute slice
////////////////////////////////////////

package rv_isa_pkg;

	// major opcodes handled by this slice
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_lui    = 7'b0110111;

	// funct3 codes, shared by op and op-imm
	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	// srl and sra share this one, funct7 tells them apart
	localparam logic [2:0] f3_sr   = 3'b101;
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	// bit 30 set, selects sub and sra
	localparam logic [6:0] f7_alt = 7'b0100000;

	// register-register layout
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} instr_r_t;

	// register-immediate layout
	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} instr_i_t;

	// upper-immediate layout, lui only here
	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} instr_u_t;

	// one word, three ways to look at it
	// note the r view's funct7 overlays imm[11:5] of the i view
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
		instr_u_t u;
	} instr_u;

endpackage
